// File: Makefile
VERILATOR ?= verilator
TOP := game_loader_tb
RTL_TOP := game_loader
FILELIST := game_loader.f
OBJ_DIR := obj_dir
SIM_FLAGS := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only -Wall --timing --timescale 1ns/100ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: game_loader.f
+incdir+testbench
logic/ines_header_pkg.sv
logic/nes_memmap_pkg.sv
logic/load_sequencer.sv
logic/byte_counter.sv
logic/ines_header_decoder.sv
logic/mem_write_stager.sv
logic/game_loader.sv
testbench/game_loader_tb.sv

// File: logic/byte_counter.sv
/*
 * Region byte counter
 * Remaining bytes and next memory address of the region being loaded
 */
`default_nettype none

module byte_counter (
	input  logic clk,
	input  logic reset_nes,
	input  logic region_load,
	input  nes_memmap_pkg::load_region_t region,
	input  logic [nes_memmap_pkg::MEM_ADDR_W-1:0] region_bytes,
	input  logic data_accept,
	output logic count_zero,
	output logic [nes_memmap_pkg::MEM_ADDR_W-1:0] addr
);
	import nes_memmap_pkg::*;

	logic [MEM_ADDR_W-1:0] count;
	logic [MEM_ADDR_W-1:0] region_base;

	always_comb begin
		case (region)
			REGION_CHR: region_base = CHR_BASE;
			REGION_PRG: region_base = PRG_BASE;
			default: region_base = PRG_BASE;
		endcase
	end

	assign count_zero = (count == '0);

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			count <= '0;
			addr <= PRG_BASE;
		end else if (region_load) begin
			count <= region_bytes;
			addr <= region_base;
		end else if (data_accept) begin
			count <= count - 1'b1;
			addr <= addr + 1'b1; // Address of the following byte
		end
	end

	// The sequencer must close a region before the count underflows
	a_no_underflow: assert property (@(posedge clk) disable iff (reset_nes)
		data_accept |-> count != '0);

endmodule

`default_nettype wire

// File: logic/game_loader.sv
/*
 * Game loader top level
 * Streams an iNES image into cartridge memory and decodes its mapper flags
 */
`default_nettype none

module game_loader (
	input  logic clk,
	input  logic reset_nes,
	input  logic [7:0] in_byte,
	input  logic in_valid,
	input  logic invert_mirroring,
	output nes_memmap_pkg::mem_wr_t mem_wr,
	output ines_header_pkg::mapper_flags_t mapper_flags,
	output logic busy,
	output logic done,
	output logic error
);
	import nes_memmap_pkg::*;

	logic header_write;
	logic [3:0] header_index;
	logic header_valid;
	logic [MEM_ADDR_W-1:0] prg_bytes;
	logic [MEM_ADDR_W-1:0] chr_bytes;
	logic [MEM_ADDR_W-1:0] region_bytes;
	logic [MEM_ADDR_W-1:0] addr;
	logic region_load;
	load_region_t region;
	logic data_accept;
	logic count_zero;

	load_sequencer load_sequencer_inst (
		.clk(clk),
		.reset_nes(reset_nes),
		.in_valid(in_valid),
		.header_valid(header_valid),
		.prg_bytes(prg_bytes),
		.chr_bytes(chr_bytes),
		.count_zero(count_zero),
		.header_write(header_write),
		.header_index(header_index),
		.region_load(region_load),
		.region(region),
		.region_bytes(region_bytes),
		.data_accept(data_accept),
		.busy(busy),
		.done(done),
		.error(error)
	);

	byte_counter byte_counter_inst (
		.clk(clk),
		.reset_nes(reset_nes),
		.region_load(region_load),
		.region(region),
		.region_bytes(region_bytes),
		.data_accept(data_accept),
		.count_zero(count_zero),
		.addr(addr)
	);

	ines_header_decoder ines_header_decoder_inst (
		.clk(clk),
		.reset_nes(reset_nes),
		.header_write(header_write),
		.header_index(header_index),
		.in_byte(in_byte),
		.invert_mirroring(invert_mirroring),
		.header_valid(header_valid),
		.prg_bytes(prg_bytes),
		.chr_bytes(chr_bytes),
		.mapper_flags(mapper_flags)
	);

	mem_write_stager mem_write_stager_inst (
		.clk(clk),
		.reset_nes(reset_nes),
		.data_accept(data_accept),
		.addr(addr),
		.in_byte(in_byte),
		.mem_wr(mem_wr)
	);

endmodule

`default_nettype wire

// File: logic/ines_header_decoder.sv
/*
 * iNES header decoder
 * Stores the 16 header bytes, checks them and builds the mapper flags
 */
`default_nettype none

module ines_header_decoder (
	input  logic clk,
	input  logic reset_nes,
	input  logic header_write,
	input  logic [3:0] header_index,
	input  logic [7:0] in_byte,
	input  logic invert_mirroring,
	output logic header_valid,
	output logic [nes_memmap_pkg::MEM_ADDR_W-1:0] prg_bytes,
	output logic [nes_memmap_pkg::MEM_ADDR_W-1:0] chr_bytes,
	output ines_header_pkg::mapper_flags_t mapper_flags
);
	import ines_header_pkg::*;
	import nes_memmap_pkg::*;

	ines_header_t header;
	logic is_nes20;
	logic is_dirty;

	// Smallest k with pages <= 2^k, capped at the top code
	function automatic logic [SIZE_CODE_W-1:0] size_code(input logic [7:0] pages);
		logic [SIZE_CODE_W-1:0] code;
		code = SIZE_CODE_MAX;
		for (int k = SIZE_CODE_MAX - 1; k >= 0; k--) begin
			if ({1'b0, pages} <= (9'd1 << k))
				code = SIZE_CODE_W'(k);
		end
		return code;
	endfunction

	// Cleared so the console sees neutral flags before any header arrives
	always_ff @(posedge clk) begin
		if (reset_nes)
			header <= '0;
		else if (header_write)
			header.bytes[header_index] <= in_byte;
	end

	// Trainers are not supported
	assign header_valid = (header.fields.magic == INES_MAGIC) && !header.fields.flags6[2];

	assign prg_bytes = MEM_ADDR_W'(header.fields.prg_pages) * MEM_ADDR_W'(PRG_PAGE_BYTES);
	assign chr_bytes = MEM_ADDR_W'(header.fields.chr_pages) * MEM_ADDR_W'(CHR_PAGE_BYTES);

	assign is_nes20 = (header.fields.flags7[3:2] == 2'b10);

	// Old dumps often carry junk in the tail bytes
	assign is_dirty = !is_nes20 &&
		((header.fields.byte9_15[9][7:1] != '0) || (header.fields.byte9_15[10:15] != '0));

	always_comb begin
		mapper_flags.submapper = is_nes20 ? header.fields.byte8 : 8'h00;
		mapper_flags.four_screen = header.fields.flags6[3];
		mapper_flags.chr_ram = (header.fields.chr_pages == 8'h00);
		mapper_flags.mirroring = header.fields.flags6[0] ^ invert_mirroring;
		mapper_flags.chr_size = size_code(header.fields.chr_pages);
		mapper_flags.prg_size = size_code(header.fields.prg_pages);
		mapper_flags.mapper[7:4] = is_dirty ? 4'h0 : header.fields.flags7[7:4];
		mapper_flags.mapper[3:0] = header.fields.flags6[7:4]; // Low nibble
	end

endmodule

`default_nettype wire

// File: logic/ines_header_pkg.sv
/*
 * iNES header package
 * Header layout, the console's mapper-flags word and the loader states
 */
`default_nettype none

package ines_header_pkg;

	localparam int INES_HEADER_BYTES = 16;
	localparam int PRG_PAGE_BYTES = 16384;
	localparam int CHR_PAGE_BYTES = 8192;
	localparam logic [31:0] INES_MAGIC = 32'h4E45_531A; // "NES" then 1A

	// Size codes are log2 of the page count, rounded up
	localparam int SIZE_CODE_W = 3;
	localparam logic [SIZE_CODE_W-1:0] SIZE_CODE_MAX = 3'd7;

	typedef struct packed {
		logic [31:0] magic;
		logic [7:0] prg_pages; // 16 KB units
		logic [7:0] chr_pages; // 8 KB units, zero means CHR RAM
		logic [7:0] flags6;
		logic [7:0] flags7;
		logic [7:0] byte8; // NES 2.0 submapper and mapper high bits
		logic [9:15][7:0] byte9_15;
	} ines_fields_t;

	// Byte 0 sits in the top byte of the word in both views
	typedef union packed {
		logic [0:INES_HEADER_BYTES-1][7:0] bytes;
		ines_fields_t fields;
	} ines_header_t;

	typedef struct packed {
		logic [7:0] submapper;
		logic four_screen;
		logic chr_ram;
		logic mirroring; // 1 = vertical
		logic [SIZE_CODE_W-1:0] chr_size;
		logic [SIZE_CODE_W-1:0] prg_size;
		logic [7:0] mapper;
	} mapper_flags_t;

	typedef enum logic [2:0] {
		LOAD_HEADER,
		LOAD_PRG,
		LOAD_CHR,
		LOAD_DONE,
		LOAD_ERROR
	} load_state_t;

endpackage

`default_nettype wire

// File: logic/load_sequencer.sv
/*
 * Load sequencer
 * Walks header, PRG and CHR regions of the image and owns the status flags
 */
`default_nettype none

module load_sequencer (
	input  logic clk,
	input  logic reset_nes,
	input  logic in_valid,
	input  logic header_valid,
	input  logic [nes_memmap_pkg::MEM_ADDR_W-1:0] prg_bytes,
	input  logic [nes_memmap_pkg::MEM_ADDR_W-1:0] chr_bytes,
	input  logic count_zero,
	output logic header_write,
	output logic [3:0] header_index,
	output logic region_load,
	output nes_memmap_pkg::load_region_t region,
	output logic [nes_memmap_pkg::MEM_ADDR_W-1:0] region_bytes,
	output logic data_accept,
	output logic busy,
	output logic done,
	output logic error
);
	import ines_header_pkg::*;
	import nes_memmap_pkg::*;

	load_state_t state;
	logic header_last;

	assign header_write = in_valid && (state == LOAD_HEADER);
	assign header_last = header_write && (header_index == 4'(INES_HEADER_BYTES - 1));

	assign data_accept = in_valid && (state == LOAD_PRG || state == LOAD_CHR);

	// Region start loads the counter on the same edge as the state change
	always_comb begin
		region_load = 1'b0;
		region = REGION_NONE;
		region_bytes = '0;
		if (header_last && header_valid) begin
			region_load = 1'b1;
			region = REGION_PRG;
			region_bytes = prg_bytes;
		end else if (state == LOAD_PRG && count_zero) begin
			region_load = 1'b1;
			region = REGION_CHR;
			region_bytes = chr_bytes;
		end
	end

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			state <= LOAD_HEADER;
			header_index <= '0;
			busy <= 1'b0;
			done <= 1'b0;
			error <= 1'b0;
		end else begin
			if (header_write)
				header_index <= header_index + 1'b1;

			case (state)
				LOAD_HEADER: begin
					if (header_last) begin
						busy <= 1'b1;
						state <= header_valid ? LOAD_PRG : LOAD_ERROR;
					end
				end
				LOAD_PRG: begin
					if (count_zero)
						state <= LOAD_CHR;
				end
				LOAD_CHR: begin
					if (count_zero)
						state <= LOAD_DONE;
				end
				LOAD_DONE: begin // Sticky until reset
					done <= 1'b1;
					busy <= 1'b0;
				end
				LOAD_ERROR: begin
					done <= 1'b1;
					error <= 1'b1;
					busy <= 1'b0;
				end
				default: state <= LOAD_ERROR;
			endcase
		end
	end

	a_state_legal: assert property (@(posedge clk) disable iff (reset_nes)
		state inside {LOAD_HEADER, LOAD_PRG, LOAD_CHR, LOAD_DONE, LOAD_ERROR});

	a_done_not_busy: assert property (@(posedge clk) disable iff (reset_nes)
		!(done && busy));

endmodule

`default_nettype wire

// File: logic/mem_write_stager.sv
/*
 * Memory write stager
 * Holds one loader write and releases it on the console memory slot
 */
`default_nettype none

module mem_write_stager (
	input  logic clk,
	input  logic reset_nes,
	input  logic data_accept,
	input  logic [nes_memmap_pkg::MEM_ADDR_W-1:0] addr,
	input  logic [7:0] in_byte,
	output nes_memmap_pkg::mem_wr_t mem_wr
);
	import nes_memmap_pkg::*;

	logic [SLOT_PHASE_W-1:0] slot_phase;
	logic slot_open;
	logic pending;
	logic [MEM_ADDR_W-1:0] pend_addr;
	logic [7:0] pend_data;

	assign slot_open = (slot_phase == SLOT_PHASE_W'(SLOT_PERIOD - 1));

	always_ff @(posedge clk) begin
		if (reset_nes) begin
			slot_phase <= '0;
			pending <= 1'b0;
		end else begin
			slot_phase <= slot_open ? '0 : slot_phase + 1'b1; // Free running
			if (data_accept)
				pending <= 1'b1; // New byte wins over the one leaving now
			else if (slot_open)
				pending <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (data_accept) begin
			pend_addr <= addr;
			pend_data <= in_byte;
		end
	end

	always_comb begin
		mem_wr.valid = pending && slot_open;
		mem_wr.addr = pend_addr;
		mem_wr.data = pend_data;
	end

	// Every accepted byte leaves within one slot period
	a_issue_on_slot: assert property (@(posedge clk) disable iff (reset_nes)
		data_accept |=> ##[0:SLOT_PERIOD-1] mem_wr.valid);

	// Source pacing must not overrun the one-deep holding register
	a_no_overrun: assert property (@(posedge clk) disable iff (reset_nes)
		data_accept |-> (!pending || mem_wr.valid));

endmodule

`default_nettype wire

// File: logic/nes_memmap_pkg.sv
/*
 * Cartridge memory map package
 * Region bases, memory slot spacing and the write bundle
 */
`default_nettype none

package nes_memmap_pkg;

	localparam int MEM_ADDR_W = 22;

	localparam logic [MEM_ADDR_W-1:0] PRG_BASE = 22'h00_0000;
	localparam logic [MEM_ADDR_W-1:0] CHR_BASE = 22'h20_0000; // Upper half of cart memory

	// Console memory accepts one access every fourth clock
	localparam int SLOT_PERIOD = 4;
	localparam int SLOT_PHASE_W = 2;

	typedef struct packed {
		logic valid;
		logic [MEM_ADDR_W-1:0] addr;
		logic [7:0] data;
	} mem_wr_t;

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_PRG,
		REGION_CHR
	} load_region_t;

endpackage

`default_nettype wire

// File: testbench/loader_tests.svh
/*
 * Directed loader tests
 * Each test resets the DUT, streams an image and checks the response
 */
`ifndef LOADER_TESTS_SVH
`define LOADER_TESTS_SVH
`default_nettype none

function automatic header_bytes_t build_header(input logic [7:0] prg_pages,
		input logic [7:0] chr_pages, input logic [7:0] flags6, input logic [7:0] flags7);
	header_bytes_t hdr;
	hdr = '0;
	hdr[0:3] = {8'h4E, 8'h45, 8'h53, 8'h1A}; // "NES" and the DOS EOF byte
	hdr[4] = prg_pages;
	hdr[5] = chr_pages;
	hdr[6] = flags6;
	hdr[7] = flags7;
	return hdr;
endfunction

task automatic test_reset_state();
	reset_dut();
	@(negedge clk);
	check_status(1'b0, 1'b0, 1'b0, "after reset");
	check_bit(mem_wr.valid, 1'b0, "mem_wr.valid after reset");
	send_header(build_header(8'd0, 8'd0, 8'h00, 8'h00));
	check_count(wr_log.size(), 0, "writes during header");
	wait_for_done();
	check_status(1'b0, 1'b1, 1'b0, "empty image");
endtask

task automatic test_chr_ram_cart();
	reset_dut();
	send_header(build_header(8'd1, 8'd0, 8'h00, 8'h00));
	@(negedge clk);
	check_status(1'b1, 1'b0, 1'b0, "CHR-RAM cart loading");
	send_region(PRG_PAGE_BYTES, PRG_BASE, 1'b1);
	wait_for_done();
	check_status(1'b0, 1'b1, 1'b0, "CHR-RAM cart done");
	drain_writes();
	compare_writes("CHR-RAM cart");
	check_flags(mapper_flags, mapper_flags_t'{submapper: 8'h00, four_screen: 1'b0, chr_ram: 1'b1,
		mirroring: 1'b0, chr_size: 3'd0, prg_size: 3'd0, mapper: 8'h00}, "CHR-RAM cart flags");
endtask

task automatic test_prg_chr_cart();
	reset_dut();
	send_header(build_header(8'd2, 8'd1, 8'h00, 8'h00));
	send_region(2 * PRG_PAGE_BYTES, PRG_BASE, 1'b1);
	send_region(CHR_PAGE_BYTES, CHR_BASE, 1'b1);
	wait_for_done();
	check_status(1'b0, 1'b1, 1'b0, "PRG and CHR cart done");
	drain_writes();
	send_region(8, PRG_BASE, 1'b0); // Trailing bytes after done
	drain_writes();
	compare_writes("PRG and CHR cart");
	check_flags(mapper_flags, mapper_flags_t'{submapper: 8'h00, four_screen: 1'b0, chr_ram: 1'b0,
		mirroring: 1'b0, chr_size: 3'd0, prg_size: 3'd1, mapper: 8'h00}, "PRG and CHR cart flags");
endtask

task automatic run_rejected_header(input header_bytes_t hdr, input string what);
	reset_dut();
	send_header(hdr);
	wait_for_done();
	check_status(1'b0, 1'b1, 1'b1, what);
	send_region(4, PRG_BASE, 1'b0);
	drain_writes();
	check_count(wr_log.size(), 0, {what, " writes"});
endtask

task automatic test_bad_magic();
	header_bytes_t hdr;
	hdr = build_header(8'd1, 8'd0, 8'h00, 8'h00);
	hdr[3] = 8'h1B;
	run_rejected_header(hdr, "bad magic");
endtask

task automatic test_trainer();
	run_rejected_header(build_header(8'd1, 8'd0, 8'h04, 8'h00), "trainer bit");
endtask

task automatic run_flags_case(input header_bytes_t hdr, input logic invert,
		input mapper_flags_t expected, input string what);
	reset_dut();
	invert_mirroring <= invert;
	send_header(hdr);
	wait_for_done();
	check_status(1'b0, 1'b1, 1'b0, what);
	check_flags(mapper_flags, expected, what);
endtask

task automatic test_mapper_decoding();
	header_bytes_t hdr;
	hdr = build_header(8'd0, 8'd0, 8'h49, 8'h58); // NES 2.0, mapper 54 hex
	hdr[8] = 8'h31;
	run_flags_case(hdr, 1'b0, mapper_flags_t'{submapper: 8'h31, four_screen: 1'b1, chr_ram: 1'b1,
		mirroring: 1'b1, chr_size: 3'd0, prg_size: 3'd0, mapper: 8'h54}, "NES 2.0 mapper");
	// Old format with junk in the tail loses the high nibble
	hdr[7] = 8'h50;
	hdr[12] = 8'h44;
	run_flags_case(hdr, 1'b0, mapper_flags_t'{submapper: 8'h00, four_screen: 1'b1, chr_ram: 1'b1,
		mirroring: 1'b1, chr_size: 3'd0, prg_size: 3'd0, mapper: 8'h04}, "dirty iNES mapper");
	run_flags_case(build_header(8'd0, 8'd0, 8'h01, 8'h00), 1'b1, mapper_flags_t'{submapper: 8'h00,
		four_screen: 1'b0, chr_ram: 1'b1, mirroring: 1'b0, chr_size: 3'd0, prg_size: 3'd0,
		mapper: 8'h00}, "inverted mirroring");
endtask

// Flags follow the stored header, so the body is not streamed
task automatic test_large_prg_size();
	reset_dut();
	send_header(build_header(8'd40, 8'd3, 8'h00, 8'h00));
	@(negedge clk);
	check_status(1'b1, 1'b0, 1'b0, "40-page PRG loading");
	check_flags(mapper_flags, mapper_flags_t'{submapper: 8'h00, four_screen: 1'b0, chr_ram: 1'b0,
		mirroring: 1'b0, chr_size: 3'd2, prg_size: 3'd6, mapper: 8'h00}, "40-page PRG size code");
endtask

`default_nettype wire
`endif

// File: testbench/game_loader_tb.sv
/*
 * Game loader testbench
 * Streams iNES images into the loader and checks writes, flags and status
 */
`default_nettype none

module game_loader_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import ines_header_pkg::*;
	import nes_memmap_pkg::*;

	typedef logic [0:INES_HEADER_BYTES-1][7:0] header_bytes_t;

	// Bytes streamed by all tests together
	localparam int TEST_BYTES = 16 + (16 + 16384) + (16 + 40960 + 8) + 2 * (16 + 4) + 4 * 16;
	localparam int TIMEOUT_CYCLES = TEST_BYTES * SLOT_PERIOD + 4000;

	logic clk = 1'b0;
	logic reset_nes;
	logic [7:0] in_byte;
	logic in_valid;
	logic invert_mirroring;
	mem_wr_t mem_wr;
	mapper_flags_t mapper_flags;
	logic busy;
	logic done;
	logic error;

	mem_wr_t wr_log[$]; // Writes seen on the memory port
	mem_wr_t exp_q[$]; // Writes the image should produce
	integer seed = 32'hd057_8932;
	int cycle_count = 0;

	game_loader game_loader_inst (.*);

	always #2 clk = ~clk; // 4 ns period

	// Sampled mid-cycle, each valid cycle is one write
	always @(negedge clk) begin
		if (mem_wr.valid === 1'b1)
			wr_log.push_back(mem_wr);
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the loader never finished within %0d cycles", TIMEOUT_CYCLES);
			abort_run();
		end
	end

	task automatic abort_run();
		$display("Simulation FAILED");
		$fatal(1, "Run stopped at the first error");
	endtask

	task automatic check_mem_wr(input mem_wr_t actual, input mem_wr_t expected, input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s: got addr %h data %h, expected addr %h data %h",
				$time, what, actual.addr, actual.data, expected.addr, expected.data);
			abort_run();
		end
	endtask

	task automatic check_flags(input mapper_flags_t actual, input mapper_flags_t expected,
			input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s: mapper flags %h, expected %h",
				$time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_status(input logic exp_busy, input logic exp_done, input logic exp_error,
			input string what);
		if ({busy, done, error} !== {exp_busy, exp_done, exp_error}) begin
			$display("CHECK FAILED at %0t ns: %s: busy/done/error %b%b%b, expected %b%b%b",
				$time, what, busy, done, error, exp_busy, exp_done, exp_error);
			abort_run();
		end
	endtask

	task automatic check_bit(input logic actual, input logic expected, input string what);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s: got %b, expected %b", $time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_count(input int actual, input int expected, input string what);
		if (actual != expected) begin
			$display("CHECK FAILED at %0t ns: %s: got %0d, expected %0d", $time, what, actual, expected);
			abort_run();
		end
	endtask

	task automatic reset_dut();
		@(posedge clk);
		reset_nes <= 1'b1;
		in_valid <= 1'b0;
		invert_mirroring <= 1'b0;
		repeat (3) @(posedge clk);
		reset_nes <= 1'b0;
		wr_log.delete();
		exp_q.delete();
	endtask

	// One byte per slot period, strobe high for a single cycle
	task automatic send_byte(input logic [7:0] value);
		@(posedge clk);
		in_byte <= value;
		in_valid <= 1'b1;
		@(posedge clk);
		in_valid <= 1'b0;
		repeat (SLOT_PERIOD - 2) @(posedge clk);
	endtask

	task automatic send_header(input header_bytes_t hdr);
		for (int i = 0; i < INES_HEADER_BYTES; i++)
			send_byte(hdr[i]);
	endtask

	task automatic send_region(input int count, input logic [MEM_ADDR_W-1:0] base,
			input bit expect_wr);
		logic [7:0] value;
		mem_wr_t wr;
		for (int i = 0; i < count; i++) begin
			value = 8'($random(seed));
			if (expect_wr) begin
				wr.valid = 1'b1;
				wr.addr = base + MEM_ADDR_W'(i); // Base plus index within the region
				wr.data = value;
				exp_q.push_back(wr);
			end
			send_byte(value);
		end
	endtask

	task automatic wait_for_done();
		@(negedge clk);
		while (!done)
			@(negedge clk);
	endtask

	// Last staged write may leave up to one slot after done
	task automatic drain_writes();
		repeat (SLOT_PERIOD + 1) @(negedge clk);
	endtask

	task automatic compare_writes(input string what);
		check_count(wr_log.size(), exp_q.size(), {what, " write count"});
		foreach (exp_q[i])
			check_mem_wr(wr_log[i], exp_q[i], what);
	endtask

	`include "loader_tests.svh"

	initial begin
		reset_nes <= 1'b1;
		in_byte <= 8'h00;
		in_valid <= 1'b0;
		invert_mirroring <= 1'b0;
		test_reset_state();
		test_chr_ram_cart();
		test_prg_chr_cart();
		test_bad_magic();
		test_trainer();
		test_mapper_decoding();
		test_large_prg_size();
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire
